// ==== audio_mix_pkg.sv ====
// **************************************************
// audio mixer shared types
// sample, frame and configuration widths plus the master register address.
// **************************************************

package audio_mix_pkg;

    // one signed audio sample.
    typedef logic signed [15:0] sample_t;

    // one stereo word, right channel in bits 15..0 and left channel in bits 31..16.
    typedef logic [31:0] frame_t;

    // attenuation or output shift amount, 0 to 3.
    typedef logic [1:0] shift_t;

    // configuration bus address and write data.
    typedef logic [3:0] cfg_addr_t;
    typedef logic [7:0] cfg_data_t;

    // lane registers sit at addresses 0 to lane_count-1, the master shift at the top.
    localparam cfg_addr_t master_addr = 4'd15;

endpackage

// ==== lane_ctrl_regs.sv ====
// **************************************************
// mixer configuration registers
// per-lane attenuation and mute, plus the master output shift.
// **************************************************

`timescale 1ns/1ps

module lane_ctrl_regs #(
    parameter int lane_count = 4
) (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   cfg_we,
    input  audio_mix_pkg::cfg_addr_t               cfg_addr,
    input  audio_mix_pkg::cfg_data_t               cfg_wdata,
    output audio_mix_pkg::shift_t [lane_count-1:0] lane_shift,
    output logic [lane_count-1:0]                  lane_mute,
    output audio_mix_pkg::shift_t                  master_shift
);

    logic [lane_count-1:0]  lane_hit;
    logic                   master_hit;
    audio_mix_pkg::shift_t  wdata_shift;
    logic                   wdata_mute;

    // **************************************************
    // address decode
    // **************************************************

    // bits 1..0 carry the shift, bit 2 the mute. The other bits are ignored.
    assign wdata_shift = cfg_wdata[1:0];
    assign wdata_mute  = cfg_wdata[2];

    always_comb begin
        for (int i = 0; i < lane_count; i++) begin
            lane_hit[i] = cfg_we && (cfg_addr == audio_mix_pkg::cfg_addr_t'(i));
        end
        master_hit = cfg_we && (cfg_addr == audio_mix_pkg::master_addr);
    end

    // **************************************************
    // registers
    // **************************************************

    always_ff @(posedge clk) begin
        if (rst) begin
            lane_shift <= '0;
            lane_mute  <= '0;
        end else begin
            for (int i = 0; i < lane_count; i++) begin
                if (lane_hit[i]) begin
                    lane_shift[i] <= wdata_shift;
                    lane_mute[i]  <= wdata_mute;
                end
            end
        end
    end

    // the master shift is only read at the output stage of the tree.
    always_ff @(posedge clk) begin
        if (rst) begin
            master_shift <= '0;
        end else if (master_hit) begin
            master_shift <= wdata_shift;
        end
    end

endmodule

// ==== lane_gain.sv ====
// **************************************************
// per-lane gain stage
// captures one stereo frame and applies attenuation and mute.
// **************************************************

`timescale 1ns/1ps

module lane_gain (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  en,
    input  logic                  accept,
    input  audio_mix_pkg::shift_t shift,
    input  logic                  mute,
    input  audio_mix_pkg::frame_t in_frame,
    output audio_mix_pkg::frame_t out_frame
);

    audio_mix_pkg::sample_t left_in;
    audio_mix_pkg::sample_t right_in;
    audio_mix_pkg::sample_t left_att;
    audio_mix_pkg::sample_t right_att;

    assign left_in  = in_frame[31:16];
    assign right_in = in_frame[15:0];

    // sample_t is signed, so these are arithmetic shifts and keep the sign.
    assign left_att  = left_in >>> shift;
    assign right_att = right_in >>> shift;

    // a bubble or a muted lane registers zero, so it adds nothing to the sum.
    always_ff @(posedge clk) begin
        if (rst) begin
            out_frame <= '0;
        end else if (en) begin
            if (accept && !mute) begin
                out_frame <= {left_att, right_att};
            end else begin
                out_frame <= '0;
            end
        end
    end

endmodule

// ==== mix_sum_tree.sv ====
// **************************************************
// pipelined stereo adder tree
// sums all lanes per channel, applies the master shift and saturates.
// **************************************************

`timescale 1ns/1ps

module mix_sum_tree #(
    parameter int lane_count = 4
) (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   en,
    input  logic                                   accept,
    input  logic                                   accept_last,
    input  audio_mix_pkg::shift_t                  master_shift,
    input  audio_mix_pkg::frame_t [lane_count-1:0] lane_frames,
    output audio_mix_pkg::frame_t                  out_data,
    output logic                                   out_valid,
    output logic                                   out_last
);

    localparam int depth = $clog2(lane_count);
    localparam int sum_w = 16 + depth;

    localparam logic signed [sum_w-1:0] sat_max = 32767;
    localparam logic signed [sum_w-1:0] sat_min = -32768;

    // flags run one stage longer than the tree, to cover the lane_gain stage.
    logic [depth:0] vld_sr;
    logic [depth:0] last_sr;

    logic signed [sum_w-1:0] shifted_l;
    logic signed [sum_w-1:0] shifted_r;
    audio_mix_pkg::sample_t  sat_l;
    audio_mix_pkg::sample_t  sat_r;

    function automatic audio_mix_pkg::sample_t saturate(input logic signed [sum_w-1:0] v);
        audio_mix_pkg::sample_t r;
        if (v > sat_max) begin
            r = 16'sh7fff;
        end else if (v < sat_min) begin
            r = 16'sh8000;
        end else begin
            r = audio_mix_pkg::sample_t'(v);
        end
        return r;
    endfunction

    // **************************************************
    // adder tree
    // **************************************************

    // level 0 is the lane_gain output itself. Every further level halves the
    // node count and grows the width by one bit, so no sum can overflow.
    for (genvar lvl = 0; lvl <= depth; lvl++) begin : level_g
        localparam int w = 16 + lvl;
        localparam int n = lane_count >> lvl;

        logic signed [w-1:0] sum_l [n];
        logic signed [w-1:0] sum_r [n];

        if (lvl == 0) begin : leaf_g
            for (genvar i = 0; i < n; i++) begin : split_g
                assign sum_l[i] = lane_frames[i][31:16];
                assign sum_r[i] = lane_frames[i][15:0];
            end
        end else begin : node_g
            always_ff @(posedge clk) begin
                if (en) begin
                    for (int i = 0; i < n; i++) begin
                        sum_l[i] <= level_g[lvl-1].sum_l[2*i] + level_g[lvl-1].sum_l[2*i+1];
                        sum_r[i] <= level_g[lvl-1].sum_r[2*i] + level_g[lvl-1].sum_r[2*i+1];
                    end
                end
            end
        end
    end

    // **************************************************
    // flag pipeline
    // **************************************************

    always_ff @(posedge clk) begin
        if (rst) begin
            vld_sr  <= '0;
            last_sr <= '0;
        end else if (en) begin
            vld_sr  <= {vld_sr[depth-1:0], accept};
            last_sr <= {last_sr[depth-1:0], accept && accept_last};
        end
    end

    // **************************************************
    // output stage
    // **************************************************

    assign shifted_l = level_g[depth].sum_l[0] >>> master_shift;
    assign shifted_r = level_g[depth].sum_r[0] >>> master_shift;
    assign sat_l     = saturate(shifted_l);
    assign sat_r     = saturate(shifted_r);

    always_ff @(posedge clk) begin
        if (en) begin
            out_data <= {sat_l, sat_r};
        end
    end

    // the whole pipeline holds while downstream stalls, so the word stays stable.
    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
            out_last  <= 1'b0;
        end else if (en) begin
            out_valid <= vld_sr[depth];
            out_last  <= last_sr[depth];
        end
    end

endmodule

// ==== audio_mix_tx.sv ====
// **************************************************
// transmit-side audio mixer
// mixes lane_count stereo streams into one saturated stereo stream.
// **************************************************

`timescale 1ns/1ps

module audio_mix_tx #(
    parameter int lane_count = 4
) (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   cfg_we,
    input  audio_mix_pkg::cfg_addr_t               cfg_addr,
    input  audio_mix_pkg::cfg_data_t               cfg_wdata,
    input  audio_mix_pkg::frame_t [lane_count-1:0] in_data,
    input  logic [lane_count-1:0]                  in_valid,
    input  logic [lane_count-1:0]                  in_last,
    output logic [lane_count-1:0]                  in_ready,
    output audio_mix_pkg::frame_t                  out_data,
    output logic                                   out_valid,
    output logic                                   out_last,
    input  logic                                   out_ready
);

    audio_mix_pkg::shift_t [lane_count-1:0] lane_shift;
    logic [lane_count-1:0]                  lane_mute;
    audio_mix_pkg::shift_t                  master_shift;
    audio_mix_pkg::frame_t [lane_count-1:0] lane_frames;

    logic en;
    logic accept;
    logic accept_last;

    // a set is taken only when every lane has a word and the pipeline moves.
    assign en          = out_ready;
    assign accept      = &in_valid;
    assign accept_last = &in_last;
    assign in_ready    = {lane_count{en && accept}};

    lane_ctrl_regs #(
        .lane_count   (lane_count)
    ) lane_ctrl_regs_i (
        .clk          (clk),
        .rst          (rst),
        .cfg_we       (cfg_we),
        .cfg_addr     (cfg_addr),
        .cfg_wdata    (cfg_wdata),
        .lane_shift   (lane_shift),
        .lane_mute    (lane_mute),
        .master_shift (master_shift)
    );

    for (genvar i = 0; i < lane_count; i++) begin : lane_g
        lane_gain lane_gain_i (
            .clk       (clk),
            .rst       (rst),
            .en        (en),
            .accept    (accept),
            .shift     (lane_shift[i]),
            .mute      (lane_mute[i]),
            .in_frame  (in_data[i]),
            .out_frame (lane_frames[i])
        );
    end

    mix_sum_tree #(
        .lane_count   (lane_count)
    ) mix_sum_tree_i (
        .clk          (clk),
        .rst          (rst),
        .en           (en),
        .accept       (accept),
        .accept_last  (accept_last),
        .master_shift (master_shift),
        .lane_frames  (lane_frames),
        .out_data     (out_data),
        .out_valid    (out_valid),
        .out_last     (out_last)
    );

endmodule

// ==== audio_mix_tx_assertions.sv ====
// **************************************************
// audio mixer protocol checks
// bound to the mixer top level to check reset, stall and ready rules.
// **************************************************

`timescale 1ns/1ps

module audio_mix_tx_assertions #(
    parameter int lane_count = 4
) (
    input logic                  clk,
    input logic                  rst,
    input logic [lane_count-1:0] in_ready,
    input audio_mix_pkg::frame_t out_data,
    input logic                  out_valid,
    input logic                  out_last,
    input logic                  out_ready
);

    // the output stage is empty right after a reset edge.
    reset_empty_a: assert property (@(posedge clk) rst |=> !out_valid && !out_last)
        else $error("out_valid or out_last high in the cycle after reset");

    // a stalled word must not change until downstream takes it.
    stall_hold_a: assert property (@(posedge clk) disable iff (rst)
        (out_valid && !out_ready) |=>
            ($stable(out_data) && $stable(out_valid) && $stable(out_last)))
        else $error("output word changed while out_ready was low");

    ready_needs_out_ready_a: assert property (@(posedge clk) (|in_ready) |-> out_ready)
        else $error("in_ready high while out_ready is low");

endmodule

bind audio_mix_tx audio_mix_tx_assertions #(
    .lane_count (lane_count)
) audio_mix_tx_assertions_i (
    .clk        (clk),
    .rst        (rst),
    .in_ready   (in_ready),
    .out_data   (out_data),
    .out_valid  (out_valid),
    .out_last   (out_last),
    .out_ready  (out_ready)
);

// ==== audio_mix_tx_tb.sv ====
// **************************************************
// audio mixer testbench
// replays the test data file through the mixer and checks every output word.
// **************************************************

`timescale 1ns/1ps

module audio_mix_tx_tb;

    localparam int lane_count   = 4;
    localparam int accept_limit = 200;
    localparam int output_limit = 3000;
    localparam int drain_cycles = 10;

    logic                                   clk;
    logic                                   rst;
    logic                                   cfg_we;
    audio_mix_pkg::cfg_addr_t               cfg_addr;
    audio_mix_pkg::cfg_data_t               cfg_wdata;
    audio_mix_pkg::frame_t [lane_count-1:0] in_data;
    logic [lane_count-1:0]                  in_valid;
    logic [lane_count-1:0]                  in_last;
    logic [lane_count-1:0]                  in_ready;
    audio_mix_pkg::frame_t                  out_data;
    logic                                   out_valid;
    logic                                   out_last;
    logic                                   out_ready;

    logic                     stall_mode;
    logic [32*lane_count-1:0] set_q[$];
    logic                     set_last_q[$];
    audio_mix_pkg::frame_t    exp_q[$];
    audio_mix_pkg::frame_t    got_data[$];
    logic                     got_last[$];

    string test_name;
    int    error_count;
    int    tests_run;
    int    tests_bad;
    logic  timed_out;

    audio_mix_tx #(
        .lane_count (lane_count)
    ) audio_mix_tx_i (
        .clk        (clk),
        .rst        (rst),
        .cfg_we     (cfg_we),
        .cfg_addr   (cfg_addr),
        .cfg_wdata  (cfg_wdata),
        .in_data    (in_data),
        .in_valid   (in_valid),
        .in_last    (in_last),
        .in_ready   (in_ready),
        .out_data   (out_data),
        .out_valid  (out_valid),
        .out_last   (out_last),
        .out_ready  (out_ready)
    );

    always #10 clk = ~clk;

    // downstream ready is random while a test runs with stalls.
    always @(negedge clk) begin
        if (stall_mode) begin
            out_ready = ($urandom_range(3) != 0);
        end else begin
            out_ready = 1'b1;
        end
    end

    always @(posedge clk) begin
        if (!rst && out_valid && out_ready) begin
            got_data.push_back(out_data);
            got_last.push_back(out_last);
        end
    end

    // **************************************************
    // stimulus tasks
    // **************************************************

    task automatic write_cfg(input audio_mix_pkg::cfg_addr_t a, input audio_mix_pkg::cfg_data_t d);
        @(negedge clk);
        cfg_we    = 1'b1;
        cfg_addr  = a;
        cfg_wdata = d;
        @(negedge clk);
        cfg_we    = 1'b0;
    endtask

    task automatic check_ready_rules();
        logic [lane_count-1:0] exp_ready;
        exp_ready = ((&in_valid) && out_ready) ? '1 : '0;
        if (in_ready !== exp_ready) begin
            $display("CHECK FAILED test %s in_ready: expected %b actual %b",
                     test_name, exp_ready, in_ready);
            error_count++;
        end
    endtask

    task automatic drive_sets();
        int                    waited;
        int                    rnd;
        logic                  accepted;
        logic [lane_count-1:0] vld;
        for (int k = 0; k < set_q.size(); k++) begin
            accepted = 1'b0;
            waited   = 0;
            while (!accepted && !timed_out) begin
                @(negedge clk);
                vld = '1;
                if (stall_mode && $urandom_range(3) == 0) begin
                    vld[$urandom_range(lane_count - 1)] = 1'b0;
                end
                // a set without last still raises last on some lanes.
                rnd      = $urandom_range((1 << lane_count) - 2);
                in_data  = set_q[k];
                in_last  = set_last_q[k] ? '1 : rnd[lane_count-1:0];
                in_valid = vld;
                @(posedge clk);
                check_ready_rules();
                accepted = in_ready[0];
                waited++;
                if (!accepted && waited >= accept_limit) begin
                    $display("timeout: set %0d of test %s was never accepted", k, test_name);
                    timed_out = 1'b1;
                end
            end
        end
        @(negedge clk);
        in_valid = '0;
        in_last  = '0;
    endtask

    // **************************************************
    // checking tasks
    // **************************************************

    task automatic compare_words();
        int n;
        n = (got_data.size() < exp_q.size()) ? got_data.size() : exp_q.size();
        if (got_data.size() != exp_q.size()) begin
            $display("CHECK FAILED test %s word count: expected %0d actual %0d",
                     test_name, exp_q.size(), got_data.size());
            error_count++;
        end
        for (int i = 0; i < n; i++) begin
            if (got_data[i] !== exp_q[i]) begin
                $display("CHECK FAILED test %s word %0d data: expected %08h actual %08h",
                         test_name, i, exp_q[i], got_data[i]);
                error_count++;
            end
            if (got_last[i] !== set_last_q[i]) begin
                $display("CHECK FAILED test %s word %0d last: expected %0d actual %0d",
                         test_name, i, set_last_q[i], got_last[i]);
                error_count++;
            end
        end
    endtask

    task automatic report_test(input int errors_before, input int words);
        tests_run++;
        if (error_count == errors_before) begin
            $display("test %s: ok, %0d words", test_name, words);
        end else begin
            tests_bad++;
            $display("test %s: %0d errors", test_name, error_count - errors_before);
        end
    endtask

    task automatic run_test();
        int waited;
        int errors_before;
        errors_before = error_count;
        got_data.delete();
        got_last.delete();
        drive_sets();
        waited = 0;
        while (got_data.size() < exp_q.size() && !timed_out) begin
            @(negedge clk);
            waited++;
            if (waited >= output_limit) begin
                $display("timeout: test %s got only %0d of %0d words",
                         test_name, got_data.size(), exp_q.size());
                timed_out = 1'b1;
            end
        end
        // let any extra word come out before comparing.
        stall_mode = 1'b0;
        repeat (drain_cycles) @(negedge clk);
        compare_words();
        report_test(errors_before, got_data.size());
    endtask

    task automatic check_reset_state();
        int errors_before;
        errors_before = error_count;
        test_name = "reset_state";
        @(negedge clk);
        in_valid = 4'b1011;
        @(posedge clk);
        if (out_valid !== 1'b0) begin
            $display("CHECK FAILED test %s out_valid: expected 0 actual %0d", test_name, out_valid);
            error_count++;
        end
        if (out_last !== 1'b0) begin
            $display("CHECK FAILED test %s out_last: expected 0 actual %0d", test_name, out_last);
            error_count++;
        end
        if (in_ready !== '0) begin
            $display("CHECK FAILED test %s in_ready: expected 0 actual %b", test_name, in_ready);
            error_count++;
        end
        @(negedge clk);
        in_valid = '0;
        report_test(errors_before, 0);
    endtask

    // **************************************************
    // main sequence
    // **************************************************

    initial begin
        int          fd;
        int          code;
        int          seed;
        int          rnd;
        int          lst;
        string       line;
        string       kw;
        string       nm;
        logic [31:0] f0;
        logic [31:0] f1;
        logic [31:0] f2;
        logic [31:0] f3;
        logic [31:0] ex;
        logic [31:0] addr;
        logic [31:0] data;
        logic        done;

        seed        = $urandom(32'h98b1);
        clk         = 1'b0;
        rst         = 1'b1;
        cfg_we      = 1'b0;
        cfg_addr    = '0;
        cfg_wdata   = '0;
        in_data     = '0;
        in_valid    = '0;
        in_last     = '0;
        out_ready   = 1'b1;
        stall_mode  = 1'b0;
        error_count = 0;
        tests_run   = 0;
        tests_bad   = 0;
        timed_out   = 1'b0;
        done        = 1'b0;

        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_reset_state();

        fd = $fopen("audio_mix_testdata.txt", "r");
        if (fd == 0) begin
            $display("could not open audio_mix_testdata.txt");
            error_count++;
            done = 1'b1;
        end
        while (!done && !timed_out) begin
            code = $fgets(line, fd);
            if (code == 0) begin
                done = 1'b1;
                continue;
            end
            code = $sscanf(line, "%s", kw);
            if (code < 1 || kw.getc(0) == "#") begin
                continue;
            end
            if (kw == "test") begin
                code = $sscanf(line, "%s %s %d", kw, nm, rnd);
                test_name  = nm;
                stall_mode = (rnd != 0);
                set_q.delete();
                set_last_q.delete();
                exp_q.delete();
            end else if (kw == "write") begin
                code = $sscanf(line, "%s %h %h", kw, addr, data);
                write_cfg(addr[3:0], data[7:0]);
            end else if (kw == "frame") begin
                code = $sscanf(line, "%s %h %h %h %h %d %h", kw, f0, f1, f2, f3, lst, ex);
                if (code != 7) begin
                    $display("test %s: malformed frame line in test data", test_name);
                    error_count++;
                end
                set_q.push_back({f3, f2, f1, f0});
                set_last_q.push_back(lst != 0);
                exp_q.push_back(ex);
            end else if (kw == "end") begin
                run_test();
            end else begin
                $display("unknown line in test data: %s", kw);
                error_count++;
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end

        $display("summary: tests=%0d ok=%0d bad=%0d check_errors=%0d",
                 tests_run, tests_run - tests_bad, tests_bad, error_count);
        if (error_count == 0 && tests_bad == 0 && !timed_out) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== audio_mix.f ====
audio_mix_pkg.sv
lane_ctrl_regs.sv
lane_gain.sv
mix_sum_tree.sv
audio_mix_tx.sv
audio_mix_tx_assertions.sv
audio_mix_tx_tb.sv

// ==== audio_mix_testdata.txt ====
# test <name> <stalls 0/1> | write <addr hex> <data hex> | end closes a test
# frame <lane0> <lane1> <lane2> <lane3> <last> <expected output>, hex words, left in upper half
test unity_mix 0
write 0 00
write 1 00
write 2 00
write 3 00
write F 00
frame 00010002 00030004 00050006 00070008 0 00100014
frame 0100FFFF 0200FFFE 03000001 04000000 0 0A00FFFE
frame FFF00010 FFF00010 0010FFF0 00000000 1 FFF00010
frame 12340000 00001234 00000000 00000000 0 12341234
frame 70000001 0FFF0001 00000001 00000001 1 7FFF0004
end
test lane_controls 0
write 0 01
write 1 02
write 2 04
write 3 03
write F 00
write 5 07
frame 01000100 01000100 7FFF7FFF 01000100 0 00E000E0
frame FF00FFFF FF00FFFF 80008000 FF00FFF8 0 FF20FFFD
frame 0003FFFD 0007FFF9 11112222 000FFFF1 1 0003FFFA
end
test master_shift_1 1
write 0 00
write 1 00
write 2 00
write 3 00
write F 01
frame 4000C000 4000C000 00000000 00000000 0 4000C000
frame 7FFF8000 7FFF8000 7FFF8000 7FFF8000 0 7FFF8000
frame 0003FFFD 0002FFFE 00000000 00000000 1 0002FFFD
end
test master_shift_3 0
write 0 00
write 1 00
write 2 00
write 3 00
write F 03
frame 7FFF8000 7FFF8000 7FFF8000 7FFF8000 0 3FFFC000
frame 40000001 40000001 40000001 00000001 1 18000000
end
test saturation 1
write 0 00
write 1 00
write 2 00
write 3 00
write F 00
frame 70009000 70009000 00000000 00000000 0 7FFF8000
frame 7FFF8000 0001FFFF 00000000 00000000 1 7FFF8000
frame 7FFF8000 00010001 FFFF0000 00000000 0 7FFF8001
end
test backpressure 1
write 0 01
write 1 00
write 2 00
write 3 04
write F 00
write 8 07
frame 00100020 00010002 00030004 7FFF7FFF 0 000C0016
frame 00200040 00020004 00060008 12345678 0 0018002C
frame 00400080 00040008 000C0010 00000000 1 00300058
frame FFE0FFC0 FFFFFFFE FFFDFFFC 11111111 0 FFECFFDA
frame 10002000 10002000 10002000 10002000 0 28005000
frame 01000200 03000400 05000600 07000800 1 08800B00
frame 00020004 00000000 00000000 00000000 0 00010002
frame 00000000 00000000 00000000 FFFFFFFF 0 00000000
frame 00FE00FC 00010001 00010001 00000000 0 00810080
frame FFFEFFFC 00100020 00200010 00000000 1 002F002E
frame 6000A000 6000A000 00000000 00000000 1 7FFF8000
end
